/* verilog/pq_pkg.sv */
`default_nettype none

package pq_pkg;

	// Node memory geometry
	localparam int L2_MAX_SIZE = 5;
	localparam int MAX_SIZE = 2 ** L2_MAX_SIZE;
	// Head and tail nodes never hold an entry
	localparam int CAPACITY = MAX_SIZE - 2;

	localparam int RANK_W = 10;
	localparam int HSP_W = 10;
	localparam int MDP_W = 10;
	localparam int META_W = HSP_W + MDP_W;

	typedef logic [L2_MAX_SIZE-1:0] node_t;
	typedef logic [RANK_W-1:0] rank_t;
	typedef logic [L2_MAX_SIZE-1:0] count_t;

	// Whole word on ports, two fields in the node memory
	typedef union packed {
		logic [META_W-1:0] word;
		struct packed {
			logic [HSP_W-1:0] hsp;
			logic [MDP_W-1:0] mdp;
		} fld;
	} meta_t;

	localparam node_t HEAD_NODE = node_t'(0);
	localparam node_t TAIL_NODE = node_t'(1);
	localparam node_t FIRST_FREE = node_t'(2);
	localparam node_t NULL_NODE = '1;
	localparam rank_t MIN_RANK = '0;
	localparam rank_t MAX_RANK = '1;

	// Main controller states
	localparam logic [2:0] CTRL_INIT_HEAD = 3'd0;
	localparam logic [2:0] CTRL_INIT_TAIL = 3'd1;
	localparam logic [2:0] CTRL_IDLE = 3'd2;
	localparam logic [2:0] CTRL_INSERTING = 3'd3;
	localparam logic [2:0] CTRL_REMOVING = 3'd4;

	// Insert engine states
	localparam logic [1:0] INS_IDLE = 2'd0;
	localparam logic [1:0] INS_ADDR = 2'd1;
	localparam logic [1:0] INS_DATA = 2'd2;
	localparam logic [1:0] INS_LINK = 2'd3;

	// Remove engine states
	localparam logic [2:0] RMV_IDLE = 3'd0;
	localparam logic [2:0] RMV_TAIL = 3'd1;
	localparam logic [2:0] RMV_DEQ = 3'd2;
	localparam logic [2:0] RMV_OUT = 3'd3;
	localparam logic [2:0] RMV_LINK = 3'd4;

endpackage

`default_nettype wire

/* verilog/node_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface node_mem_if;

	// Read port, data valid one cycle after the address
	pq_pkg::node_t rd_addr;
	pq_pkg::rank_t rd_rank;
	pq_pkg::meta_t rd_meta;
	pq_pkg::node_t rd_rptr;
	pq_pkg::node_t rd_lptr;

	// Rank and metadata write
	pq_pkg::node_t data_addr;
	logic data_we;
	pq_pkg::rank_t data_rank;
	pq_pkg::meta_t data_meta;

	// Right and left pointer writes
	pq_pkg::node_t rptr_addr;
	logic rptr_we;
	pq_pkg::node_t rptr_data;
	pq_pkg::node_t lptr_addr;
	logic lptr_we;
	pq_pkg::node_t lptr_data;

	modport user (
		output rd_addr, data_addr, data_we, data_rank, data_meta,
		output rptr_addr, rptr_we, rptr_data, lptr_addr, lptr_we, lptr_data,
		input rd_rank, rd_meta, rd_rptr, rd_lptr
	);

	modport mem (
		input rd_addr, data_addr, data_we, data_rank, data_meta,
		input rptr_addr, rptr_we, rptr_data, lptr_addr, lptr_we, lptr_data,
		output rd_rank, rd_meta, rd_rptr, rd_lptr
	);

endinterface

`default_nettype wire

/* verilog/node_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module node_mem (
	input wire clk,
	node_mem_if.mem port
);

	pq_pkg::rank_t rank_mem [pq_pkg::MAX_SIZE];
	logic [pq_pkg::HSP_W-1:0] hsp_mem [pq_pkg::MAX_SIZE];
	logic [pq_pkg::MDP_W-1:0] mdp_mem [pq_pkg::MAX_SIZE];
	pq_pkg::node_t rptr_mem [pq_pkg::MAX_SIZE];
	pq_pkg::node_t lptr_mem [pq_pkg::MAX_SIZE];

	always_ff @(posedge clk)
	begin
		// Metadata split into its two stored fields
		if (port.data_we)
		begin
			rank_mem[port.data_addr] <= port.data_rank;
			hsp_mem[port.data_addr] <= port.data_meta.fld.hsp;
			mdp_mem[port.data_addr] <= port.data_meta.fld.mdp;
		end
		if (port.rptr_we)
			rptr_mem[port.rptr_addr] <= port.rptr_data;
		if (port.lptr_we)
			lptr_mem[port.lptr_addr] <= port.lptr_data;
	end

	// Whole node read at once, old contents on a same-cycle write
	always_ff @(posedge clk)
	begin
		port.rd_rank <= rank_mem[port.rd_addr];
		port.rd_meta.fld.hsp <= hsp_mem[port.rd_addr];
		port.rd_meta.fld.mdp <= mdp_mem[port.rd_addr];
		port.rd_rptr <= rptr_mem[port.rd_addr];
		port.rd_lptr <= lptr_mem[port.rd_addr];
	end

endmodule

`default_nettype wire

/* verilog/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list (
	input wire clk,
	input wire rst,
	input wire pop,
	input wire push,
	input wire pq_pkg::node_t push_node,
	output pq_pkg::node_t new_node
);

	pq_pkg::node_t fifo_mem [pq_pkg::MAX_SIZE];
	pq_pkg::node_t wr_ptr;
	pq_pkg::node_t rd_ptr;
	pq_pkg::node_t fresh;
	logic fifo_empty;

	// Never full since at most CAPACITY nodes are out of the list
	assign fifo_empty = (wr_ptr == rd_ptr);

	// Returned nodes first, then never-used ones
	assign new_node = fifo_empty ? fresh : fifo_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			fifo_mem[wr_ptr] <= push_node;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fresh <= pq_pkg::FIRST_FREE;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && fifo_empty)
				fresh <= fresh + 1'b1;
			if (pop && !fifo_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/list_insert.sv */
`timescale 1ns/1ps
`default_nettype none

module list_insert (
	input wire clk,
	input wire rst,
	input wire start,
	input wire pq_pkg::rank_t rank,
	input wire pq_pkg::meta_t meta,
	input wire pq_pkg::node_t new_node,
	output logic pop,
	output logic done,
	node_mem_if.user mem
);

	logic [1:0] state;
	pq_pkg::rank_t rank_q;
	pq_pkg::meta_t meta_q;
	// Node under read, becomes the right neighbor when the walk stops
	pq_pkg::node_t cur;
	pq_pkg::node_t left;
	logic stop;
	logic link;

	// First node not outranking the new one, so equal ranks stay FIFO
	assign stop = (state == pq_pkg::INS_DATA) && (cur != pq_pkg::HEAD_NODE)
		&& (mem.rd_rank <= rank_q);
	assign link = (state == pq_pkg::INS_LINK);

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= pq_pkg::INS_IDLE;
		else
		begin
			case (state)
			pq_pkg::INS_IDLE:
				if (start)
					state <= pq_pkg::INS_ADDR;
			pq_pkg::INS_ADDR:
				state <= pq_pkg::INS_DATA;
			pq_pkg::INS_DATA:
				state <= stop ? pq_pkg::INS_LINK : pq_pkg::INS_ADDR;
			default:
				state <= pq_pkg::INS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			rank_q <= rank;
			meta_q <= meta;
			cur <= pq_pkg::HEAD_NODE;
		end
		else if (state == pq_pkg::INS_DATA && !stop)
		begin
			left <= cur;
			cur <= mem.rd_rptr;
		end
	end

	assign mem.rd_addr = cur;

	// New node written as the walk stops
	assign mem.data_we = stop;
	assign mem.data_addr = new_node;
	assign mem.data_rank = rank_q;
	assign mem.data_meta = meta_q;

	// Neighbors point to the new node one cycle later
	assign mem.rptr_we = stop || link;
	assign mem.rptr_addr = stop ? new_node : left;
	assign mem.rptr_data = stop ? cur : new_node;
	assign mem.lptr_we = stop || link;
	assign mem.lptr_addr = stop ? new_node : cur;
	assign mem.lptr_data = stop ? left : new_node;

	assign pop = link;
	assign done = link;

endmodule

`default_nettype wire

/* verilog/list_remove.sv */
`timescale 1ns/1ps
`default_nettype none

module list_remove (
	input wire clk,
	input wire rst,
	input wire start,
	output pq_pkg::rank_t rank_out,
	output pq_pkg::meta_t meta_out,
	output logic valid_out,
	output logic push,
	output pq_pkg::node_t push_node,
	output logic done,
	node_mem_if.user mem
);

	logic [2:0] state;
	pq_pkg::node_t left;
	logic link;

	assign link = (state == pq_pkg::RMV_LINK);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= pq_pkg::RMV_IDLE;
			valid_out <= 1'b0;
		end
		else
		begin
			valid_out <= (state == pq_pkg::RMV_OUT);
			case (state)
			pq_pkg::RMV_IDLE:
				if (start)
					state <= pq_pkg::RMV_TAIL;
			pq_pkg::RMV_TAIL:
				state <= pq_pkg::RMV_DEQ;
			pq_pkg::RMV_DEQ:
				state <= pq_pkg::RMV_OUT;
			pq_pkg::RMV_OUT:
				state <= pq_pkg::RMV_LINK;
			default:
				state <= pq_pkg::RMV_IDLE;
			endcase
		end
	end

	// Entry held on the outputs until the next remove
	always_ff @(posedge clk)
	begin
		if (state == pq_pkg::RMV_DEQ)
			push_node <= mem.rd_lptr;
		if (state == pq_pkg::RMV_OUT)
		begin
			rank_out <= mem.rd_rank;
			meta_out <= mem.rd_meta;
			left <= mem.rd_lptr;
		end
	end

	// Tail first, then the node its left pointer names
	assign mem.rd_addr = (state == pq_pkg::RMV_DEQ) ? mem.rd_lptr : pq_pkg::TAIL_NODE;

	// No rank or metadata is ever written here
	assign mem.data_we = 1'b0;
	assign mem.data_addr = pq_pkg::TAIL_NODE;
	assign mem.data_rank = pq_pkg::MIN_RANK;
	assign mem.data_meta = '0;

	// Left neighbor and tail close the gap
	assign mem.rptr_we = link;
	assign mem.rptr_addr = left;
	assign mem.rptr_data = pq_pkg::TAIL_NODE;
	assign mem.lptr_we = link;
	assign mem.lptr_addr = pq_pkg::TAIL_NODE;
	assign mem.lptr_data = left;

	assign push = link;
	assign done = link;

endmodule

`default_nettype wire

/* verilog/list_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module list_ctrl (
	input wire clk,
	input wire rst,
	input wire insert,
	input wire remove,
	output logic busy,
	output logic ins_start,
	input wire ins_done,
	output logic rmv_start,
	input wire rmv_done,
	node_mem_if.mem ins_port,
	node_mem_if.mem rmv_port,
	node_mem_if.user mem_port
);

	logic [2:0] state;
	pq_pkg::count_t count;
	logic init;
	logic init_tail;

	assign busy = (state != pq_pkg::CTRL_IDLE);
	assign init_tail = (state == pq_pkg::CTRL_INIT_TAIL);
	assign init = (state == pq_pkg::CTRL_INIT_HEAD) || init_tail;

	// Remove wins over a simultaneous insert
	assign rmv_start = !busy && remove && (count != '0);
	assign ins_start = !busy && insert && !remove
		&& (count != pq_pkg::count_t'(pq_pkg::CAPACITY));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= pq_pkg::CTRL_INIT_HEAD;
			count <= '0;
		end
		else
		begin
			case (state)
			pq_pkg::CTRL_INIT_HEAD:
				state <= pq_pkg::CTRL_INIT_TAIL;
			pq_pkg::CTRL_INIT_TAIL:
				state <= pq_pkg::CTRL_IDLE;
			pq_pkg::CTRL_IDLE:
				if (rmv_start)
					state <= pq_pkg::CTRL_REMOVING;
				else if (ins_start)
					state <= pq_pkg::CTRL_INSERTING;
			pq_pkg::CTRL_INSERTING:
				if (ins_done)
				begin
					state <= pq_pkg::CTRL_IDLE;
					count <= count + 1'b1;
				end
			pq_pkg::CTRL_REMOVING:
				if (rmv_done)
				begin
					state <= pq_pkg::CTRL_IDLE;
					count <= count - 1'b1;
				end
			default:
				state <= pq_pkg::CTRL_INIT_HEAD;
			endcase
		end
	end

	// Both engines see the same read data
	assign ins_port.rd_rank = mem_port.rd_rank;
	assign ins_port.rd_meta = mem_port.rd_meta;
	assign ins_port.rd_rptr = mem_port.rd_rptr;
	assign ins_port.rd_lptr = mem_port.rd_lptr;
	assign rmv_port.rd_rank = mem_port.rd_rank;
	assign rmv_port.rd_meta = mem_port.rd_meta;
	assign rmv_port.rd_rptr = mem_port.rd_rptr;
	assign rmv_port.rd_lptr = mem_port.rd_lptr;

	always_comb
	begin
		if (state == pq_pkg::CTRL_INSERTING)
		begin
			mem_port.rd_addr = ins_port.rd_addr;
			mem_port.data_addr = ins_port.data_addr;
			mem_port.data_we = ins_port.data_we;
			mem_port.data_rank = ins_port.data_rank;
			mem_port.data_meta = ins_port.data_meta;
			mem_port.rptr_addr = ins_port.rptr_addr;
			mem_port.rptr_we = ins_port.rptr_we;
			mem_port.rptr_data = ins_port.rptr_data;
			mem_port.lptr_addr = ins_port.lptr_addr;
			mem_port.lptr_we = ins_port.lptr_we;
			mem_port.lptr_data = ins_port.lptr_data;
		end
		else if (state == pq_pkg::CTRL_REMOVING)
		begin
			mem_port.rd_addr = rmv_port.rd_addr;
			mem_port.data_addr = rmv_port.data_addr;
			mem_port.data_we = rmv_port.data_we;
			mem_port.data_rank = rmv_port.data_rank;
			mem_port.data_meta = rmv_port.data_meta;
			mem_port.rptr_addr = rmv_port.rptr_addr;
			mem_port.rptr_we = rmv_port.rptr_we;
			mem_port.rptr_data = rmv_port.rptr_data;
			mem_port.lptr_addr = rmv_port.lptr_addr;
			mem_port.lptr_we = rmv_port.lptr_we;
			mem_port.lptr_data = rmv_port.lptr_data;
		end
		else
		begin
			// Head then tail, no writes while idle
			mem_port.rd_addr = pq_pkg::HEAD_NODE;
			mem_port.data_addr = init_tail ? pq_pkg::TAIL_NODE : pq_pkg::HEAD_NODE;
			mem_port.data_we = init;
			mem_port.data_rank = init_tail ? pq_pkg::MIN_RANK : pq_pkg::MAX_RANK;
			mem_port.data_meta.word = '0;
			mem_port.rptr_addr = init_tail ? pq_pkg::TAIL_NODE : pq_pkg::HEAD_NODE;
			mem_port.rptr_we = init;
			mem_port.rptr_data = init_tail ? pq_pkg::NULL_NODE : pq_pkg::TAIL_NODE;
			mem_port.lptr_addr = init_tail ? pq_pkg::TAIL_NODE : pq_pkg::HEAD_NODE;
			mem_port.lptr_we = init;
			mem_port.lptr_data = init_tail ? pq_pkg::HEAD_NODE : pq_pkg::NULL_NODE;
		end
	end

endmodule

`default_nettype wire

/* verilog/skip_list_pq.sv */
`timescale 1ns/1ps
`default_nettype none

module skip_list_pq (
	input wire clk,
	input wire rst,
	input wire insert,
	input wire remove,
	input wire pq_pkg::rank_t rank_in,
	input wire pq_pkg::meta_t meta_in,
	output pq_pkg::rank_t rank_out,
	output pq_pkg::meta_t meta_out,
	output logic valid_out,
	output logic busy
);

	logic ins_start;
	logic ins_done;
	logic rmv_start;
	logic rmv_done;
	logic pop;
	logic push;
	pq_pkg::node_t new_node;
	pq_pkg::node_t push_node;

	node_mem_if ins_if ();
	node_mem_if rmv_if ();
	node_mem_if mem_if ();

	list_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.insert    (insert),
		.remove    (remove),
		.busy      (busy),
		.ins_start (ins_start),
		.ins_done  (ins_done),
		.rmv_start (rmv_start),
		.rmv_done  (rmv_done),
		.ins_port  (ins_if.mem),
		.rmv_port  (rmv_if.mem),
		.mem_port  (mem_if.user)
	);

	list_insert u_insert (
		.clk      (clk),
		.rst      (rst),
		.start    (ins_start),
		.rank     (rank_in),
		.meta     (meta_in),
		.new_node (new_node),
		.pop      (pop),
		.done     (ins_done),
		.mem      (ins_if.user)
	);

	list_remove u_remove (
		.clk       (clk),
		.rst       (rst),
		.start     (rmv_start),
		.rank_out  (rank_out),
		.meta_out  (meta_out),
		.valid_out (valid_out),
		.push      (push),
		.push_node (push_node),
		.done      (rmv_done),
		.mem       (rmv_if.user)
	);

	node_mem u_mem (
		.clk  (clk),
		.port (mem_if.mem)
	);

	free_list u_free (
		.clk       (clk),
		.rst       (rst),
		.pop       (pop),
		.push      (push),
		.push_node (push_node),
		.new_node  (new_node)
	);

endmodule

`default_nettype wire

/* test/pq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pq_checker (
	input wire clk,
	input wire rst,
	input wire insert,
	input wire remove,
	input wire pq_pkg::rank_t rank_in,
	input wire pq_pkg::meta_t meta_in,
	input wire pq_pkg::rank_t rank_out,
	input wire pq_pkg::meta_t meta_out,
	input wire valid_out,
	input wire busy,
	output int compares,
	output int value_errors,
	output int protocol_errors
);

	// Reference queue kept in insert order
	pq_pkg::rank_t ref_rank [$];
	logic [pq_pkg::META_W-1:0] ref_meta [$];
	logic rmv_pending;
	logic started;
	logic accepted;
	logic ignored;
	// Last entry shown with valid_out
	logic held;
	pq_pkg::rank_t held_rank;
	logic [pq_pkg::META_W-1:0] held_meta;

	// Smallest rank leaves first, the oldest one among equals
	function automatic int next_out();
		int best;
		best = 0;
		for (int i = 1; i < ref_rank.size(); i++)
		begin
			if (ref_rank[i] < ref_rank[best])
				best = i;
		end
		return best;
	endfunction

	task automatic note_protocol(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		protocol_errors++;
	endtask

	// Inputs change on the falling edge, so everything is stable here
	always @(posedge clk)
	begin
		int idx;
		if (rst)
		begin
			compares = 0;
			value_errors = 0;
			protocol_errors = 0;
			rmv_pending = 1'b0;
			started = 1'b0;
			accepted = 1'b0;
			ignored = 1'b0;
			held = 1'b0;
			ref_rank.delete();
			ref_meta.delete();
		end
		else
		begin
			if (!started && busy !== 1'b1)
				note_protocol("busy was not high in the first cycle after reset");
			started = 1'b1;
			if (accepted && !busy)
				note_protocol("busy did not rise after an accepted command");
			if (ignored && busy)
				note_protocol("busy rose after a command that should be ignored");
			accepted = 1'b0;
			ignored = 1'b0;

			// Outputs keep the last entry between removes
			if (held && !rmv_pending && !valid_out)
			begin
				if (rank_out !== held_rank)
				begin
					$display("FAILED rank_out at %0t ns: got %h, expected %h",
						$time, rank_out, held_rank);
					value_errors++;
				end
				if (meta_out.word !== held_meta)
				begin
					$display("FAILED meta_out at %0t ns: got %h, expected %h",
						$time, meta_out.word, held_meta);
					value_errors++;
				end
			end

			if (valid_out)
			begin
				if (!rmv_pending)
					note_protocol("valid_out pulsed without an accepted remove");
				else
				begin
					idx = next_out();
					compares++;
					if (rank_out !== ref_rank[idx])
					begin
						$display("FAILED rank_out at %0t ns: got %h, expected %h",
							$time, rank_out, ref_rank[idx]);
						value_errors++;
					end
					if (meta_out.word !== ref_meta[idx])
					begin
						$display("FAILED meta_out at %0t ns: got %h, expected %h",
							$time, meta_out.word, ref_meta[idx]);
						value_errors++;
					end
					held = 1'b1;
					held_rank = ref_rank[idx];
					held_meta = ref_meta[idx];
					ref_rank.delete(idx);
					ref_meta.delete(idx);
					rmv_pending = 1'b0;
				end
			end
			else if (rmv_pending && !busy)
			begin
				note_protocol("remove ended without a valid_out pulse");
				// Keep the model in step with the DUT
				idx = next_out();
				ref_rank.delete(idx);
				ref_meta.delete(idx);
				rmv_pending = 1'b0;
			end

			// Remove wins when both commands are raised
			if (!busy && remove)
			begin
				if (ref_rank.size() > 0)
				begin
					accepted = 1'b1;
					rmv_pending = 1'b1;
				end
				else
					ignored = 1'b1;
			end
			else if (!busy && insert)
			begin
				if (ref_rank.size() < pq_pkg::CAPACITY)
				begin
					accepted = 1'b1;
					ref_rank.push_back(rank_in);
					ref_meta.push_back(meta_in.word);
				end
				else
					ignored = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_skip_list_pq.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_skip_list_pq;

	localparam int CLK_PERIOD = 100;
	localparam int BASIC_COUNT = 20;
	localparam int MIX_COUNT = 300;
	// Every command the sequence below issues
	localparam int TOTAL_CMDS = 1 + 2 * BASIC_COUNT + 2 * (pq_pkg::CAPACITY + 1) + 5
		+ MIX_COUNT + pq_pkg::CAPACITY;
	// An insert may walk the whole list
	localparam int WORST_CYCLES = 2 * pq_pkg::MAX_SIZE + 6;

	logic clk;
	logic rst;
	logic insert;
	logic remove;
	pq_pkg::rank_t rank_in;
	pq_pkg::meta_t meta_in;
	pq_pkg::rank_t rank_out;
	pq_pkg::meta_t meta_out;
	logic valid_out;
	logic busy;
	logic [15:0] lfsr;
	int compares;
	int value_errors;
	int protocol_errors;

	skip_list_pq u_dut (
		.clk       (clk),
		.rst       (rst),
		.insert    (insert),
		.remove    (remove),
		.rank_in   (rank_in),
		.meta_in   (meta_in),
		.rank_out  (rank_out),
		.meta_out  (meta_out),
		.valid_out (valid_out),
		.busy      (busy)
	);

	pq_checker u_chk (
		.clk             (clk),
		.rst             (rst),
		.insert          (insert),
		.remove          (remove),
		.rank_in         (rank_in),
		.meta_in         (meta_in),
		.rank_out        (rank_out),
		.meta_out        (meta_out),
		.valid_out       (valid_out),
		.busy            (busy),
		.compares        (compares),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors)
	);

	initial
		clk = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Taps 16, 14, 13, 11, shifting left
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw(input int width, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < width; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Waits for idle, then holds the command over one rising edge
	task automatic issue(input logic ins, input logic rmv, input pq_pkg::rank_t rank,
		input logic [pq_pkg::META_W-1:0] meta);
		while (busy)
			@(negedge clk);
		insert = ins;
		remove = rmv;
		rank_in = rank;
		meta_in.word = meta;
		@(negedge clk);
		insert = 1'b0;
		remove = 1'b0;
		// Changed so a late sample shows up as a mismatch
		rank_in = ~rank;
		meta_in.word = ~meta;
	endtask

	// Four rank bits give plenty of ties
	task automatic random_insert();
		logic [31:0] r;
		logic [31:0] m;
		draw(4, r);
		draw(pq_pkg::META_W, m);
		issue(1'b1, 1'b0, pq_pkg::rank_t'(r), m[pq_pkg::META_W-1:0]);
	endtask

	initial
	begin
		logic [31:0] pick;
		lfsr = 16'd53911;
		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		rank_in = '0;
		meta_in.word = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// Remove on an empty queue as soon as init ends
		issue(1'b0, 1'b1, '0, '0);
		repeat (4) @(negedge clk);

		repeat (BASIC_COUNT) random_insert();
		repeat (BASIC_COUNT) issue(1'b0, 1'b1, '0, '0);

		// One insert past capacity, one remove past empty
		repeat (pq_pkg::CAPACITY + 1) random_insert();
		repeat (pq_pkg::CAPACITY + 1) issue(1'b0, 1'b1, '0, '0);

		// Both commands at once, only the remove happens
		random_insert();
		random_insert();
		issue(1'b1, 1'b1, pq_pkg::MAX_RANK, '1);
		issue(1'b0, 1'b1, '0, '0);
		issue(1'b0, 1'b1, '0, '0);

		// Mostly inserts first, mostly removes later
		for (int i = 0; i < MIX_COUNT; i++)
		begin
			draw(2, pick);
			if ((pick[1:0] != 2'd0) == (i < MIX_COUNT / 2))
				random_insert();
			else
				issue(1'b0, 1'b1, '0, '0);
		end
		repeat (pq_pkg::CAPACITY) issue(1'b0, 1'b1, '0, '0);

		while (busy)
			@(negedge clk);
		repeat (4) @(negedge clk);

		$display("Compares: %0d, value errors: %0d, protocol errors: %0d",
			compares, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(TOTAL_CMDS * WORST_CYCLES * CLK_PERIOD + 200 * CLK_PERIOD);
		$display("Timeout: the test sequence did not finish in time");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
verilog/pq_pkg.sv
verilog/node_mem_if.sv
verilog/node_mem.sv
verilog/free_list.sv
verilog/list_insert.sv
verilog/list_remove.sv
verilog/list_ctrl.sv
verilog/skip_list_pq.sv
test/pq_checker.sv
test/tb_skip_list_pq.sv

/* run.sh */
#!/bin/sh
# Build and run the priority queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_skip_list_pq -f filelist.f -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/Vtb_skip_list_pq); then
	printf '%s\n' "$output"
	echo "Simulation exited with an error"
	exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
